// ==== hw/fpDiv_cfg.svh ====
// binary16 layout constants for the divide unit
// the datapath is tied to these values, so changing them alone does not retarget the format
`ifndef FPDIV_CFG_SVH
`define FPDIV_CFG_SVH

// exponent and fraction field widths
`define FP_NE 5
`define FP_NF 10

// exponent bias of the format
`define FP_BIAS 15

// quotient bits made by the restoring divide
// integer bit at the top, set for a quotient of at least 1
`define FP_QBITS 14

// largest biased exponent, the infinity encoding
`define FP_EMAX 31

`endif

// ==== hw/fpDivPkg.sv ====
// shared types of the half-precision divide unit
// widths follow the macros of the config header
`default_nettype none

`include "fpDiv_cfg.svh"

package fpDivPkg;

  // packed binary16 word, sign on top
  typedef struct packed {
    logic              sign;
    logic [`FP_NE-1:0] exp;
    logic [`FP_NF-1:0] frac;
  } fp16T;

  // mantissa with its hidden bit
  typedef logic [`FP_NF:0] mantT;

  // signed working exponent, two extra bits for under- and overflow
  typedef logic signed [`FP_NE+1:0] expT;

  // raw quotient and the corrected mantissa
  typedef logic [`FP_QBITS-1:0] quotT;
  typedef logic [`FP_QBITS-1:0] corrT;

  // exception flags of one result
  typedef struct packed {
    logic overflow;
    logic underflow;
    logic inexact;
  } flagsT;

endpackage

`default_nettype wire

// ==== hw/divCtrl.sv ====
// sequencer of the divide unit: idle, iterate, pack, done
// start is only taken in idle, a start while busy is dropped
// done follows the pack cycle by exactly one clock
`timescale 1ns/1ps
`default_nettype none

module divCtrl (
  input  logic clk,
  input  logic arstN,
  input  logic start,
  input  logic lastIter,
  output logic load,
  output logic iterEn,
  output logic packEn,
  output logic busy,
  output logic done
);

  typedef enum logic [1:0] {
    sIdle,
    sIter,
    sPack,
    sDone
  } stateT;

  stateT state;
  stateT stateNext;

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) state <= sIdle;
    else        state <= stateNext;
  end

  // next state
  always_comb begin
    stateNext = state;
    case (state)
      sIdle: if (start) stateNext = sIter;
      // leave after the step where the counter reads zero
      sIter: if (lastIter) stateNext = sPack;
      sPack: stateNext = sDone;
      sDone: stateNext = sIdle;
      default: stateNext = sIdle;
    endcase
  end

  ////////////////////////////////////////
  // decoded outputs
  ////////////////////////////////////////
  // operands are captured in the same cycle start is seen
  assign load   = (state == sIdle) & start;
  assign iterEn = (state == sIter);
  assign packEn = (state == sPack);
  assign busy   = (state != sIdle);
  assign done   = (state == sDone);

  // the result register must have been written the cycle before done
  doneAfterPack: assert property (@(posedge clk) disable iff (!arstN)
    done |-> $past(packEn))
    else $error("done raised without a pack cycle before it");

endmodule

`default_nettype wire

// ==== hw/iterCounter.sv ====
// counts the quotient steps down from FP_QBITS-1
// one spare top bit marks a count that has run past zero
`timescale 1ns/1ps
`default_nettype none

`include "fpDiv_cfg.svh"

module iterCounter (
  input  logic clk,
  input  logic arstN,
  input  logic load,
  input  logic iterEn,
  output logic lastIter
);

  localparam int cntW = $clog2(`FP_QBITS) + 1;

  logic [cntW-1:0] cnt;

  // resets to all ones so lastIter stays low while idle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)      cnt <= '1;
    else if (load)   cnt <= cntW'(`FP_QBITS - 1);
    else if (iterEn) cnt <= cnt - 1'b1;
  end

  assign lastIter = (cnt == '0);

  // the sequencer must stop stepping once the final bit is made
  noStepPastZero: assert property (@(posedge clk) disable iff (!arstN)
    iterEn |-> !cnt[cntW-1])
    else $error("quotient step requested after the last iteration");

endmodule

`default_nettype wire

// ==== hw/quotientIter.sv ====
// radix-2 restoring divide of the two mantissas, one quotient bit per iterEn
// operands are taken as normal, finite and non-zero, no special cases here
// qm ends as floor(mantA * 2^(FP_QBITS-1) / mantB)
`timescale 1ns/1ps
`default_nettype none

`include "fpDiv_cfg.svh"

module quotientIter (
  input  logic            clk,
  input  logic            arstN,
  input  logic            load,
  input  logic            iterEn,
  input  fpDivPkg::fp16T  a,
  input  fpDivPkg::fp16T  b,
  output fpDivPkg::quotT  qm,
  output logic            remNz,
  output fpDivPkg::expT   divUe,
  output logic            sign
);

  import fpDivPkg::*;

  mantT mantA;
  mantT mantB;
  mantT mantBReg;
  expT  expDiff;

  // partial remainder, always below twice the divisor
  logic [`FP_NF+1:0] rem;
  logic [`FP_NF+1:0] remSub;
  logic              geB;

  ////////////////////////////////////////
  // operand unpack
  ////////////////////////////////////////
  assign mantA = {1'b1, a.frac};
  assign mantB = {1'b1, b.frac};

  // biased exponent of the raw quotient, range -14 to 44
  assign expDiff = expT'({2'b00, a.exp}) - expT'({2'b00, b.exp}) + expT'(`FP_BIAS);

  ////////////////////////////////////////
  // restoring step
  ////////////////////////////////////////
  // compare and subtract, the remainder after it is below mantB
  assign geB    = (rem >= {1'b0, mantBReg});
  assign remSub = geB ? rem - {1'b0, mantBReg} : rem;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      qm    <= '0;
      rem   <= '0;
      sign  <= 1'b0;
      divUe <= '0;
    end else if (load) begin
      qm    <= '0;
      rem   <= {1'b0, mantA};
      sign  <= a.sign ^ b.sign;
      divUe <= expDiff;
    end else if (iterEn) begin
      // new bit enters at the bottom, remainder doubles for the next weight
      qm  <= {qm[`FP_QBITS-2:0], geB};
      rem <= {remSub[`FP_NF:0], 1'b0};
    end
  end

  // divisor held for the whole iteration
  always_ff @(posedge clk) begin
    if (load) mantBReg <= mantB;
  end

  // doubling keeps zero at zero, so the last remainder is exact for this test
  assign remNz = |rem;

endmodule

`default_nettype wire

// ==== hw/subnormShift.sv ====
// subnormal detection and right shift of the raw quotient
// a subnormal result leaves with its fraction in the top FP_NF bits of shifted
// a shift wider than the quotient gives zero, all bits go to sticky
`timescale 1ns/1ps
`default_nettype none

`include "fpDiv_cfg.svh"

module subnormShift (
  input  fpDivPkg::quotT qm,
  input  fpDivPkg::expT  divUe,
  output fpDivPkg::quotT shifted,
  output logic           divResSubnorm,
  output logic           divSubnormShiftPos,
  output logic           stickyShift
);

  import fpDivPkg::*;

  expT  normExp;
  expT  sAmt;
  quotT shiftedRaw;

  // quotient with one extra low bit, so exponent 1 with qm below 1 needs no left shift
  logic [`FP_QBITS:0] ext;
  logic [`FP_QBITS:0] lowMask;

  // exponent after normalizing a quotient in [0.5, 1)
  assign normExp = qm[`FP_QBITS-1] ? divUe : divUe - expT'(1);

  assign divResSubnorm = (normExp < expT'(1));

  // distance down to exponent 1, only looked at for subnormal results
  assign sAmt = expT'(1) - divUe;

  assign divSubnormShiftPos = (sAmt <= expT'(`FP_QBITS));

  assign ext        = {qm, 1'b0};
  assign shiftedRaw = quotT'(ext >> sAmt);
  // marks the bits that fall off the bottom
  assign lowMask    = ~({(`FP_QBITS+1){1'b1}} << sAmt);

  always_comb begin
    if (!divResSubnorm) begin
      shifted     = qm;
      stickyShift = 1'b0;
    end else if (!divSubnormShiftPos) begin
      // underflow to zero, qm is never zero so sticky is set
      shifted     = '0;
      stickyShift = |qm;
    end else begin
      shifted     = shiftedRaw;
      stickyShift = |(ext & lowMask);
    end
  end

endmodule

`default_nettype wire

// ==== hw/shiftCorrection.sv ====
// normalization fix of the divide quotient, which lies in [0.5, 2)
// normal results drop the hidden bit off the top of mf
// subnormal results are already aligned by the subnormal shift
`timescale 1ns/1ps
`default_nettype none

`include "fpDiv_cfg.svh"

module shiftCorrection (
  input  fpDivPkg::quotT shifted,
  input  logic           divResSubnorm,
  input  fpDivPkg::expT  divUe,
  input  logic           divSubnormShiftPos,
  output fpDivPkg::corrT mf,
  output fpDivPkg::expT  ue
);

  import fpDivPkg::*;

  corrT corrQm1;
  corrT corrQm2;
  logic topBit;

  // integer bit of the quotient, set for a quotient of at least 1
  assign topBit = shifted[`FP_QBITS-1];

  // one place left for [1, 2), two places for [0.5, 1)
  assign corrQm1 = {shifted[`FP_QBITS-2:0], 1'b0};
  assign corrQm2 = {shifted[`FP_QBITS-3:0], 2'b00};

  ////////////////////////////////////////
  // mantissa select
  ////////////////////////////////////////
  always_comb begin
    if (divResSubnorm) mf = shifted;
    else if (topBit)   mf = corrQm1;
    else               mf = corrQm2;
  end

  ////////////////////////////////////////
  // exponent
  ////////////////////////////////////////
  // subnormal results carry a zero exponent field
  // a quotient below 1 costs one from the exponent
  always_comb begin
    if (divResSubnorm & divSubnormShiftPos) ue = '0;
    else if (topBit)                        ue = divUe;
    else                                    ue = divUe - expT'(1);
  end

endmodule

`default_nettype wire

// ==== hw/resultPack.sv ====
// packs sign, exponent and fraction with round toward zero
// overflow saturates to signed infinity, result and flags held until the next pack
`timescale 1ns/1ps
`default_nettype none

`include "fpDiv_cfg.svh"

module resultPack (
  input  logic            clk,
  input  logic            arstN,
  input  logic            packEn,
  input  logic            sign,
  input  fpDivPkg::corrT  mf,
  input  fpDivPkg::expT   ue,
  input  logic            divResSubnorm,
  input  logic            remNz,
  input  logic            stickyShift,
  output fpDivPkg::fp16T  result,
  output fpDivPkg::flagsT flags
);

  import fpDivPkg::*;

  fp16T  resNext;
  flagsT flagsNext;
  logic  ovf;
  logic  lostBits;

  assign ovf = (ue >= expT'(`FP_EMAX));
  // bits below the fraction that truncation throws away
  assign lostBits = |mf[`FP_QBITS-`FP_NF-1:0];

  always_comb begin
    resNext.sign = sign;
    if (ovf) begin
      resNext.exp  = `FP_NE'(`FP_EMAX);
      resNext.frac = '0;
    end else begin
      // zero exponent field for subnormal and flushed results
      resNext.exp  = divResSubnorm ? '0 : ue[`FP_NE-1:0];
      resNext.frac = mf[`FP_QBITS-1 -: `FP_NF];
    end
    flagsNext.overflow  = ovf;
    flagsNext.inexact   = ovf | remNz | stickyShift | lostBits;
    flagsNext.underflow = divResSubnorm & (remNz | stickyShift | lostBits);
  end

  // output register, written in the pack cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      result <= '0;
      flags  <= '0;
    end else if (packEn) begin
      result <= resNext;
      flags  <= flagsNext;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fpDivTop.sv ====
// half-precision divide, normal finite non-zero operands, round toward zero
// done comes FP_QBITS+2 cycles after an accepted start, no back-pressure
// a start while busy is ignored
`timescale 1ns/1ps
`default_nettype none

module fpDivTop (
  input  logic            clk,
  input  logic            arstN,
  input  logic            start,
  input  fpDivPkg::fp16T  a,
  input  fpDivPkg::fp16T  b,
  output logic            busy,
  output logic            done,
  output fpDivPkg::fp16T  result,
  output fpDivPkg::flagsT flags
);

  import fpDivPkg::*;

  // control
  logic load;
  logic iterEn;
  logic lastIter;
  logic packEn;

  // divide datapath
  quotT qm;
  quotT shifted;
  corrT mf;
  expT  divUe;
  expT  ue;
  logic remNz;
  logic sign;
  logic divResSubnorm;
  logic divSubnormShiftPos;
  logic stickyShift;

  ////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////
  divCtrl uCtrl (
    .clk(clk), .arstN(arstN), .start(start), .lastIter(lastIter),
    .load(load), .iterEn(iterEn), .packEn(packEn), .busy(busy), .done(done)
  );

  iterCounter uCnt (
    .clk(clk), .arstN(arstN), .load(load), .iterEn(iterEn), .lastIter(lastIter)
  );

  ////////////////////////////////////////
  // quotient and post-processing
  ////////////////////////////////////////
  quotientIter uIter (
    .clk(clk), .arstN(arstN), .load(load), .iterEn(iterEn), .a(a), .b(b),
    .qm(qm), .remNz(remNz), .divUe(divUe), .sign(sign)
  );

  // combinational from the held quotient, settles before the pack edge
  subnormShift uSub (
    .qm(qm), .divUe(divUe), .shifted(shifted), .divResSubnorm(divResSubnorm),
    .divSubnormShiftPos(divSubnormShiftPos), .stickyShift(stickyShift)
  );

  shiftCorrection uCorr (
    .shifted(shifted), .divResSubnorm(divResSubnorm), .divUe(divUe),
    .divSubnormShiftPos(divSubnormShiftPos), .mf(mf), .ue(ue)
  );

  resultPack uPack (
    .clk(clk), .arstN(arstN), .packEn(packEn), .sign(sign), .mf(mf), .ue(ue),
    .divResSubnorm(divResSubnorm), .remNz(remNz), .stickyShift(stickyShift),
    .result(result), .flags(flags)
  );

endmodule

`default_nettype wire

// ==== testbench/fpDivTb.sv ====
// testbench of the half-precision divide unit
// operands are always normal, finite and non-zero, as the unit expects
// inputs change on the falling edge, outputs are read on the falling edge
`timescale 1ns/1ps
`default_nettype none

`include "fpDiv_cfg.svh"

module fpDivTb;

  import fpDivPkg::*;

  localparam int clkPeriod     = 4;
  localparam int resetCycles   = 10;
  localparam int latency       = `FP_QBITS + 2;
  localparam int numDirected   = 18;
  localparam int numRandom     = 4000;
  // the busy test holds the unit for about two runs
  localparam int numTests      = numDirected + numRandom + 2;
  localparam int cyclesPerTest = `FP_QBITS + 6;

  // expected result and flags of one divide
  typedef struct packed {
    fp16T  res;
    flagsT fl;
  } refT;

  logic  clk;
  logic  arstN;
  logic  start;
  fp16T  a;
  fp16T  b;
  logic  busy;
  logic  done;
  fp16T  result;
  flagsT flags;

  // outstanding divides, oldest first
  fp16T  aQ[$];
  fp16T  bQ[$];
  fp16T  resQ[$];
  flagsT flQ[$];
  int    issued;
  int    checked;
  logic [31:0] seed;

  fpDivTop i_dut (
    .clk(clk), .arstN(arstN), .start(start), .a(a), .b(b),
    .busy(busy), .done(done), .result(result), .flags(flags)
  );

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  // exact quotient as an integer ratio of mantissas, truncated toward zero
  function automatic refT refDiv(input fp16T x, input fp16T y);
    refT    r;
    int     ea;
    int     eb;
    int     be;
    int     p;
    longint num;
    longint den;
    longint q;
    logic   below;
    ea    = int'(x.exp);
    eb    = int'(y.exp);
    num   = longint'({1'b1, x.frac});
    den   = longint'({1'b1, y.frac});
    below = (num < den);
    // biased exponent of the true quotient
    be = ea - eb + `FP_BIAS - (below ? 1 : 0);
    r.res.sign = x.sign ^ y.sign;
    r.fl       = '0;
    if (be >= `FP_EMAX) begin
      r.res.exp      = `FP_NE'(`FP_EMAX);
      r.res.frac     = '0;
      r.fl.overflow  = 1'b1;
      r.fl.inexact   = 1'b1;
    end else begin
      // normal keeps FP_NF bits below the leading one, subnormal counts units of 2^-24
      if (be >= 1) p = `FP_NF + (below ? 1 : 0);
      else         p = ea - eb + `FP_BIAS + `FP_NF - 1;
      if (p >= 0) num = num << p;
      else        den = den << (-p);
      q = num / den;
      r.res.exp     = (be >= 1) ? `FP_NE'(be) : '0;
      r.res.frac    = q[`FP_NF-1:0];
      r.fl.inexact  = ((num % den) != 0);
      r.fl.underflow = (be < 1) && r.fl.inexact;
    end
    return r;
  endfunction

  // 32-bit LCG
  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // upper LCG bits only, exponent forced into 1..30
  function automatic fp16T makeOperand(input logic [31:0] r);
    fp16T v;
    v.sign = r[31];
    v.exp  = `FP_NE'(r[30:20] % 11'd30) + `FP_NE'(1);
    v.frac = r[19:10];
    return v;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic checkResult(input fp16T got, input fp16T want, input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t ns: %s gave %h, expected %h", $time, what, got, want);
      $display("Simulation failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic checkFlags(input flagsT got, input flagsT want, input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t ns: %s flags ovf/unf/inx %b, expected %b",
               $time, what, got, want);
      $display("Simulation failed");
      $fatal(1, "flags mismatch");
    end
  endtask

  task automatic checkLatency(input int got, input int want);
    if (got != want) begin
      $display("CHECK FAILED at %0t ns: done after %0d cycles, expected %0d",
               $time, got, want);
      $display("Simulation failed");
      $fatal(1, "latency mismatch");
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic pushExpected(input fp16T x, input fp16T y);
    refT r;
    r = refDiv(x, y);
    aQ.push_back(x);
    bQ.push_back(y);
    resQ.push_back(r.res);
    flQ.push_back(r.fl);
    issued++;
  endtask

  // entered on the falling edge where start was dropped
  task automatic waitDone(input int cyclesSoFar);
    int cycles;
    cycles = cyclesSoFar;
    while (!done) begin
      if (cycles > latency + 4) begin
        $display("no done from the divider within %0d cycles of start", cycles);
        $display("Simulation failed");
        $fatal(1, "missing done");
      end
      @(negedge clk);
      cycles++;
    end
    checkLatency(cycles, latency);
  endtask

  task automatic runOp(input fp16T x, input fp16T y);
    @(negedge clk);
    start = 1'b1;
    a     = x;
    b     = y;
    pushExpected(x, y);
    @(negedge clk);
    start = 1'b0;
    waitDone(1);
  endtask

  // second start while busy must be dropped
  task automatic busyStartTest(input fp16T x, input fp16T y, input fp16T x2, input fp16T y2);
    @(negedge clk);
    start = 1'b1;
    a     = x;
    b     = y;
    pushExpected(x, y);
    @(negedge clk);
    start = 1'b0;
    repeat (4) @(negedge clk);
    if (!busy) begin
      $display("busy was low in the middle of a divide");
      $display("Simulation failed");
      $fatal(1, "busy low");
    end
    start = 1'b1;
    a     = x2;
    b     = y2;
    @(negedge clk);
    start = 1'b0;
    waitDone(6);
    // a stray done here finds no expected entry
    repeat (`FP_QBITS + 4) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // response checker
  ////////////////////////////////////////
  always @(negedge clk) begin : compareOnDone
    fp16T  opA;
    fp16T  opB;
    fp16T  wantRes;
    flagsT wantFl;
    if (arstN && done) begin
      if (resQ.size() == 0) begin
        $display("done strobe at %0t ns with no divide outstanding", $time);
        $display("Simulation failed");
        $fatal(1, "unexpected done");
      end else begin
        opA     = aQ.pop_front();
        opB     = bQ.pop_front();
        wantRes = resQ.pop_front();
        wantFl  = flQ.pop_front();
        checkResult(result, wantRes, $sformatf("%h / %h", opA, opB));
        checkFlags(flags, wantFl, $sformatf("%h / %h", opA, opB));
        checked++;
      end
    end
  end

  // budget from the test count, reset included
  initial begin : watchdog
    #((numTests * cyclesPerTest + resetCycles) * clkPeriod);
    $display("timeout: the run did not finish in the expected number of cycles");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin : mainSeq
    fp16T x;
    fp16T y;
    clk     = 1'b0;
    arstN   = 1'b0;
    start   = 1'b0;
    a       = '0;
    b       = '0;
    issued  = 0;
    checked = 0;
    seed    = 32'ha097;
    repeat (resetCycles) @(negedge clk);
    arstN = 1'b1;

    // quotient mantissa in [1, 2), exact 3/1.5 among them
    runOp(16'h4200, 16'h3E00);
    runOp(16'h3E00, 16'h3C00);
    runOp(16'h57FF, 16'h3C01);
    runOp(16'hC200, 16'h3E00);
    // quotient mantissa in [0.5, 1), 1/3 inexact
    runOp(16'h3C00, 16'h4200);
    runOp(16'h3C00, 16'h3FFF);
    runOp(16'h4A00, 16'h4D00);
    // subnormal, normalized exponent exactly 0 from both sides
    runOp(16'h0600, 16'h4000);
    runOp(16'h0400, 16'h3E00);
    runOp(16'h0800, 16'h4400);
    runOp(16'h0400, 16'h5000);
    // shift at the quotient width, then past it
    runOp(16'h0401, 16'h7400);
    runOp(16'h0400, 16'h7800);
    runOp(16'h87FF, 16'h7BFF);
    // overflow to signed infinity, and the largest normal
    runOp(16'h7BFF, 16'h0400);
    runOp(16'h7800, 16'h3800);
    runOp(16'hF800, 16'h3800);
    runOp(16'h7BFF, 16'h3C00);

    busyStartTest(16'h4200, 16'h3E00, 16'h7BFF, 16'h0400);

    for (int i = 0; i < numRandom; i++) begin
      seed = lcgNext(seed);
      x    = makeOperand(seed);
      seed = lcgNext(seed);
      y    = makeOperand(seed);
      runOp(x, y);
    end

    // let the checker take the last done
    repeat (2) @(negedge clk);
    if (checked != issued || resQ.size() != 0) begin
      $display("%0d divides issued but %0d results checked", issued, checked);
      $display("Simulation failed");
      $fatal(1, "result count mismatch");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/fpDivPkg.sv
hw/divCtrl.sv
hw/iterCounter.sv
hw/quotientIter.sv
hw/subnormShift.sv
hw/shiftCorrection.sv
hw/resultPack.sv
hw/fpDivTop.sv
testbench/fpDivTb.sv

// ==== Makefile ====
# Verilator build and run of the divide unit testbench
# pass or fail comes from the log, override any variable on the command line

VERILATOR ?= verilator
TOP       ?= fpDivTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
